/* tb.f */
+incdir+include
+incdir+tests
verilog/div_msg_pkg.sv
verilog/div_ctrl_pkg.sv
verilog/int_div_dpath.sv
verilog/int_div_ctrl.sv
verilog/int_div_iterative.sv
tests/int_div_tb.sv

/* tests/int_div_ref.svh */
// Reference divide model and the value compare task
// Included inside the testbench module body

`ifndef INT_DIV_REF_SVH
`define INT_DIV_REF_SVH

`include "div_params.svh"

// Expected {remainder, quotient} from magnitudes and operand signs
function automatic div_result_t ref_div(input div_fn_e fn, input div_word_t a,
                                        input div_word_t b);
  logic      a_neg;
  logic      b_neg;
  div_word_t a_mag;
  div_word_t b_mag;
  div_word_t quo;
  div_word_t rem;
  a_neg = (fn == DIV_FN_SIGNED) && a[`DIV_WIDTH-1];  // Signs only matter when signed
  b_neg = (fn == DIV_FN_SIGNED) && b[`DIV_WIDTH-1];
  a_mag = a_neg ? -a : a;
  b_mag = b_neg ? -b : b;
  if (b_mag == '0) begin
    quo = '1;     // Zero divisor gives all ones
    rem = a_mag;  // and the dividend magnitude
  end else begin
    quo = a_mag / b_mag;
    rem = a_mag % b_mag;
  end
  if (a_neg ^ b_neg) quo = -quo;  // Exactly one sign set
  if (a_neg) rem = -rem;          // Remainder follows dividend
  return {rem, quo};
endfunction

// Compare two values, count the check, report a mismatch
task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                           input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("ERROR at time %0t: %s, got %h expected %h", $time, what, got, exp);
  end
endtask

`endif

/* tests/int_div_tb.sv */
// Testbench for the iterative divide unit
// Clock, reset, directed and random stimulus, in-order response checking

module int_div_tb
  import div_msg_pkg::*;
();

  // ----------------------------------------
  // Limits and timing
  // ----------------------------------------

  localparam int RESP_LATENCY = 33;   // Accept edge to first edge seeing resp_val
  localparam int MAX_OPS      = 230;  // Directed plus random, rounded up
  localparam int OP_CYCLES    = 45;   // 34 busy cycles plus up to 8 stall plus slack
  localparam int MARGIN       = 1650;
  localparam int TIMEOUT_CYCLES = MAX_OPS * OP_CYCLES + MARGIN;  // 12000

  logic        clk;
  logic        reset;
  div_fn_e     req_fn;
  div_word_t   req_a;
  div_word_t   req_b;
  logic        req_val;
  logic        req_rdy;
  div_result_t resp_result;
  logic        resp_val;
  logic        resp_rdy;

  int     errors = 0;
  int     checks = 0;
  int     ops_done = 0;
  int     cycle_count = 0;
  integer seed = 77793;

  `include "int_div_ref.svh"

  int_div_iterative dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------
  // Timeout
  // ----------------------------------------

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;  // Nonblocking, readers see the old count
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // Response checking
  // ----------------------------------------

  div_fn_e     q_fn[$];  // Accepted requests, oldest first
  div_word_t   q_a[$];
  div_word_t   q_b[$];
  int          accept_cycle = 0;
  logic        busy = 1'b0;          // Between accept and response transfer
  logic        hold_pending = 1'b0;  // Response stalled on the last edge
  div_result_t held_result = '0;
  logic        resp_val_d = 1'b0;

  // Sampled on the rising edge, before the DUT registers update
  always @(posedge clk) begin : check_proc
    div_fn_e   fn;
    div_word_t a;
    div_word_t b;
    if (!reset) begin
      if (busy) check_value(req_rdy, 1'b0, "req_rdy high during an operation");
      if (hold_pending) begin
        check_value(resp_val, 1'b1, "resp_val dropped under back-pressure");
        check_value(resp_result, held_result, "resp_result moved under back-pressure");
      end
      if (resp_val && !resp_val_d) begin
        check_value(cycle_count - accept_cycle, RESP_LATENCY, "response latency");
      end
      if (req_val && req_rdy) begin  // Request transfer
        q_fn.push_back(req_fn);
        q_a.push_back(req_a);
        q_b.push_back(req_b);
        accept_cycle = cycle_count;
        busy = 1'b1;
      end
      if (resp_val && resp_rdy) begin  // Response transfer
        if (q_fn.size() == 0) begin
          errors++;
          $display("Response arrived with no request outstanding at time %0t", $time);
        end else begin
          fn = q_fn.pop_front();
          a  = q_a.pop_front();
          b  = q_b.pop_front();
          check_value(resp_result, ref_div(fn, a, b),
                      $sformatf("result fn=%0d a=%h b=%h", fn, a, b));
        end
        busy = 1'b0;
      end
      hold_pending = resp_val && !resp_rdy;
      held_result  = resp_result;
      resp_val_d   = resp_val;
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  // One full operation, entered and left just after a falling edge
  task automatic run_op(input div_fn_e fn, input div_word_t a, input div_word_t b,
                        input int stall);
    int i;
    req_fn   = fn;
    req_a    = a;
    req_b    = b;
    req_val  = 1'b1;
    resp_rdy = (stall == 0);
    while (!req_rdy) @(negedge clk);  // Transfer on the next rising edge
    @(negedge clk);
    req_val = 1'b0;
    req_a   = $random(seed);          // Junk on the bus after transfer
    req_b   = $random(seed);
    while (!resp_val) @(negedge clk);
    for (i = 0; i < stall; i++) @(negedge clk);
    resp_rdy = 1'b1;
    @(negedge clk);                   // Response taken on the edge before
    ops_done++;
  endtask

  // Summary line for one finished test
  task automatic report_test(input string name, input int err_start, input int ops_start);
    $display("%s: %0d operations, %0d errors", name, ops_done - ops_start,
             errors - err_start);
  endtask

  initial begin : stim_proc
    int        err_start;
    int        ops_start;
    int        i;
    int        sel;
    div_fn_e   fn;
    div_word_t a;
    div_word_t b;

    reset    = 1'b1;
    req_fn   = DIV_FN_UNSIGNED;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (5) @(negedge clk);  // 5 rising edges under reset
    reset = 1'b0;
    @(negedge clk);

    // Test 1, reset state and unsigned directed cases
    err_start = errors;
    ops_start = ops_done;
    check_value(req_rdy, 1'b1, "req_rdy after reset");
    check_value(resp_val, 1'b0, "resp_val after reset");
    run_op(DIV_FN_UNSIGNED, 32'd100, 32'd7, 0);
    run_op(DIV_FN_UNSIGNED, 32'h1234_5678, 32'd1, 0);
    run_op(DIV_FN_UNSIGNED, 32'd5, 32'd900, 0);
    run_op(DIV_FN_UNSIGNED, 32'hffff_ffff, 32'd3, 0);
    report_test("Test 1 reset and unsigned", err_start, ops_start);

    // Test 2, all four sign combinations
    err_start = errors;
    ops_start = ops_done;
    run_op(DIV_FN_SIGNED, 32'sd7, 32'sd2, 0);
    run_op(DIV_FN_SIGNED, -32'sd7, 32'sd2, 0);
    run_op(DIV_FN_SIGNED, 32'sd7, -32'sd2, 0);
    run_op(DIV_FN_SIGNED, -32'sd7, -32'sd2, 0);
    report_test("Test 2 signed", err_start, ops_start);

    // Test 3, zero divisor and overflow case
    err_start = errors;
    ops_start = ops_done;
    run_op(DIV_FN_UNSIGNED, 32'd1234, 32'd0, 0);
    run_op(DIV_FN_SIGNED, -32'sd1234, 32'd0, 0);
    run_op(DIV_FN_SIGNED, 32'h8000_0000, 32'hffff_ffff, 0);
    report_test("Test 3 corner cases", err_start, ops_start);

    // Test 4, back to back with no stall, latency checked per op
    err_start = errors;
    ops_start = ops_done;
    run_op(DIV_FN_UNSIGNED, 32'd1000, 32'd10, 0);
    run_op(DIV_FN_SIGNED, -32'sd1000, 32'sd33, 0);
    run_op(DIV_FN_UNSIGNED, 32'hdead_beef, 32'h0000_1000, 0);
    report_test("Test 4 latency", err_start, ops_start);

    // Test 5, response held back
    err_start = errors;
    ops_start = ops_done;
    run_op(DIV_FN_UNSIGNED, 32'd99, 32'd4, 1);
    run_op(DIV_FN_SIGNED, -32'sd99, 32'sd4, 3);
    run_op(DIV_FN_SIGNED, 32'sd12345, -32'sd17, 8);
    run_op(DIV_FN_UNSIGNED, 32'hcafe_f00d, 32'd0, 5);
    report_test("Test 5 back-pressure", err_start, ops_start);

    // Test 6, random function, operands and stall
    err_start = errors;
    ops_start = ops_done;
    for (i = 0; i < 200; i++) begin
      fn  = div_fn_e'($random(seed) & 1);
      a   = $random(seed);
      sel = $unsigned($random(seed)) % 8;
      case (sel)
        0:       b = '0;                     // Zero divisor now and then
        1, 2:    b = $random(seed) & 32'hff;  // Small divisor, wide quotient
        default: b = $random(seed);
      endcase
      run_op(fn, a, b, $unsigned($random(seed)) % 9);
    end
    report_test("Test 6 random", err_start, ops_start);

    repeat (2) @(negedge clk);
    if (q_fn.size() != 0) begin
      errors++;
      $display("%0d accepted requests never got a response", q_fn.size());
    end
    $display("Totals: %0d operations, %0d checks, %0d errors", ops_done, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* verilog/int_div_iterative.sv */
// Iterative divide unit top level
// Control unit and datapath between request and response ports

module int_div_iterative
  import div_msg_pkg::*;
  import div_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  // Request port
  input  div_fn_e     req_fn,
  input  div_word_t   req_a,        // Dividend
  input  div_word_t   req_b,        // Divisor
  input  logic        req_val,
  output logic        req_rdy,

  // Response port
  output div_result_t resp_result,  // {remainder, quotient}
  output logic        resp_val,
  input  logic        resp_rdy
);

  // ----------------------------------------
  // Control to datapath
  // ----------------------------------------

  div_cmd_e cmd;

  // Handshake and iteration sequencing
  int_div_ctrl ctrl0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .cmd      (cmd)
  );

  // ----------------------------------------
  // Datapath
  // ----------------------------------------

  // Operands in, packed result out
  int_div_dpath dpath0 (
    .clk         (clk),
    .reset       (reset),
    .cmd         (cmd),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_result (resp_result)
  );

endmodule

/* verilog/int_div_ctrl.sv */
// Divide unit control
// Three-state FSM, iteration counter, handshake and datapath command

`include "div_params.svh"

module int_div_ctrl
  import div_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     req_val,
  output logic     req_rdy,
  output logic     resp_val,
  input  logic     resp_rdy,
  output div_cmd_e cmd        // To datapath
);

  // ----------------------------------------
  // State and counter
  // ----------------------------------------

  div_state_e state;
  div_state_e state_next;
  div_count_t count;        // Steps already issued
  div_count_t count_next;

  logic req_go;   // Request transfer this cycle
  logic resp_go;  // Response transfer this cycle
  logic last_step;

  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_step = (count == div_count_t'(`DIV_ITERS - 1));  // 32nd STEP

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      count <= count_next;
    end
  end

  // ----------------------------------------
  // Next state logic
  // ----------------------------------------

  always_comb begin
    state_next = state;
    count_next = count;
    case (state)
      ST_IDLE: begin
        if (req_go) begin
          state_next = ST_CALC;
          count_next = '0;       // Fresh operation
        end
      end
      ST_CALC: begin
        count_next = count + 1'b1;
        if (last_step) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        if (resp_go) begin
          state_next = ST_IDLE;  // Ready again on the next cycle
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------

  assign req_rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);  // Held until taken

  always_comb begin
    case (state)
      ST_IDLE: cmd = req_go ? DIV_CMD_LOAD : DIV_CMD_HOLD;
      ST_CALC: cmd = DIV_CMD_STEP;
      default: cmd = DIV_CMD_HOLD;       // DONE keeps the result
    endcase
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Never accept while a result is pending
  rdy_val_excl_a: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else $error("req_rdy and resp_val high together");

  // Response stays offered under back-pressure
  resp_hold_a: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val)
    else $error("resp_val dropped before transfer");

  // Counter bounded by iteration count
  count_range_a: assert property (@(posedge clk) disable iff (reset)
    count <= div_count_t'(`DIV_ITERS))
    else $error("Iteration count out of range");

endmodule

/* verilog/int_div_dpath.sv */
// Divide unit datapath
// Operand capture, sign extraction, restoring shift-subtract step
// and sign correction of quotient and remainder

`include "div_params.svh"

module int_div_dpath
  import div_msg_pkg::*;
  import div_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  div_cmd_e    cmd,          // From control unit
  input  div_fn_e     req_fn,       // Signed or unsigned
  input  div_word_t   req_a,        // Dividend
  input  div_word_t   req_b,        // Divisor
  output div_result_t resp_result   // {remainder, quotient}
);

  // ----------------------------------------
  // Request decode
  // ----------------------------------------

  logic      req_signed;
  logic      a_neg;      // Dividend needs negation
  logic      b_neg;      // Divisor needs negation
  div_word_t a_mag;
  div_word_t b_mag;

  assign req_signed = (req_fn == DIV_FN_SIGNED);

  // Sign bits only count in signed mode
  assign a_neg = req_signed && req_a[`DIV_WIDTH-1];
  assign b_neg = req_signed && req_b[`DIV_WIDTH-1];

  assign a_mag = a_neg ? div_word_t'(-req_a) : req_a;
  assign b_mag = b_neg ? div_word_t'(-req_b) : req_b;

  // ----------------------------------------
  // Operation registers
  // ----------------------------------------

  div_fn_e   fn_reg;       // Function of current operation
  logic      sign_a_reg;   // Raw dividend sign
  logic      sign_b_reg;   // Raw divisor sign
  div_word_t divisor_reg;  // Divisor magnitude
  logic      loaded_reg;   // Set once the first LOAD has happened

  // Partial remainder in upper 33 bits, quotient in lower 32
  logic [2*`DIV_WIDTH:0] rq_reg;
  logic [2*`DIV_WIDTH:0] rq_shift;
  logic [2*`DIV_WIDTH:0] rq_next;
  logic [`DIV_WIDTH:0]   diff;       // Trial subtraction, top bit is sign

  // ----------------------------------------
  // Restoring step
  // ----------------------------------------

  assign rq_shift = rq_reg << 1;

  // Upper half minus divisor, one bit wider to catch a borrow
  assign diff = rq_shift[2*`DIV_WIDTH:`DIV_WIDTH] - {1'b0, divisor_reg};

  always_comb begin
    if (!diff[`DIV_WIDTH]) begin
      // Fits, keep difference and set quotient bit
      rq_next = {diff, rq_shift[`DIV_WIDTH-1:1], 1'b1};
    end else begin
      rq_next = rq_shift;  // Restore, quotient bit stays 0
    end
  end

  // Payload registers, driven only by cmd
  always_ff @(posedge clk) begin
    case (cmd)
      DIV_CMD_LOAD: begin
        fn_reg      <= req_fn;
        sign_a_reg  <= req_a[`DIV_WIDTH-1];
        sign_b_reg  <= req_b[`DIV_WIDTH-1];
        divisor_reg <= b_mag;
        rq_reg      <= {{(`DIV_WIDTH+1){1'b0}}, a_mag};  // Dividend in low half
      end
      DIV_CMD_STEP: begin
        rq_reg <= rq_next;
      end
      default: begin
        // HOLD, nothing moves
      end
    endcase
  end

  // Tracks whether fn_reg holds a real request yet
  always_ff @(posedge clk) begin
    if (reset) begin
      loaded_reg <= 1'b0;
    end else if (cmd == DIV_CMD_LOAD) begin
      loaded_reg <= 1'b1;
    end
  end

  // ----------------------------------------
  // Sign correction
  // ----------------------------------------

  logic      fn_signed;
  logic      quo_neg;
  logic      rem_neg;
  div_word_t quo_mag;
  div_word_t rem_mag;
  div_word_t quo_out;
  div_word_t rem_out;

  assign fn_signed = (fn_reg == DIV_FN_SIGNED);

  assign quo_mag = rq_reg[`DIV_WIDTH-1:0];
  assign rem_mag = rq_reg[2*`DIV_WIDTH-1:`DIV_WIDTH];  // Top bit is always 0 when done

  // Quotient negative when exactly one operand is negative
  assign quo_neg = fn_signed && (sign_a_reg ^ sign_b_reg);
  // Remainder follows the dividend
  assign rem_neg = fn_signed && sign_a_reg;

  assign quo_out = quo_neg ? div_word_t'(-quo_mag) : quo_mag;
  assign rem_out = rem_neg ? div_word_t'(-rem_mag) : rem_mag;

  assign resp_result = {rem_out, quo_out};

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Once a request was captured the function must be known
  fn_known_a: assert property (@(posedge clk) disable iff (reset)
    loaded_reg |-> !$isunknown(fn_reg))
    else $error("Divider function register unknown after LOAD");

endmodule

/* verilog/div_ctrl_pkg.sv */
// Control types for the divide unit
// FSM state, datapath command, iteration counter

`include "div_params.svh"

package div_ctrl_pkg;

  // Control FSM states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,  // Waiting for a request
    ST_CALC = 2'd1,  // Shift-subtract in progress
    ST_DONE = 2'd2   // Result waiting on response port
  } div_state_e;

  // Command from control to datapath
  typedef enum logic [1:0] {
    DIV_CMD_HOLD = 2'd0,  // Keep all datapath state
    DIV_CMD_LOAD = 2'd1,  // Capture request operands
    DIV_CMD_STEP = 2'd2   // One restoring iteration
  } div_cmd_e;

  // Iteration counter
  typedef logic [`DIV_COUNT_WIDTH-1:0] div_count_t;

endpackage

/* verilog/div_msg_pkg.sv */
// Message types for the divide unit request and response
// Operand word, packed result, function select

`include "div_params.svh"

package div_msg_pkg;

  // ----------------------------------------
  // Data words
  // ----------------------------------------

  // Operand, quotient or remainder
  typedef logic [`DIV_WIDTH-1:0] div_word_t;

  // Response word, {remainder, quotient}
  typedef logic [`DIV_RESULT_WIDTH-1:0] div_result_t;

  // ----------------------------------------
  // Request function
  // ----------------------------------------

  typedef enum logic {
    DIV_FN_UNSIGNED = 1'b0,  // Operands taken as is
    DIV_FN_SIGNED   = 1'b1   // Two's complement operands
  } div_fn_e;

endpackage

/* include/div_params.svh */
// Width and iteration constants for the iterative divide unit
// Operand, result, step count and counter sizes

`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// ----------------------------------------
// Operand and result widths
// ----------------------------------------

`define DIV_WIDTH        32  // Dividend, divisor, quotient, remainder
`define DIV_RESULT_WIDTH 64  // Remainder in upper half, quotient in lower

// ----------------------------------------
// Iteration control
// ----------------------------------------

// One quotient bit per step
`define DIV_ITERS        32
// Must hold DIV_ITERS itself, not only DIV_ITERS-1
`define DIV_COUNT_WIDTH  6

`endif
